/* include/plca_defs.svh */
`ifndef PLCA_DEFS_SVH
`define PLCA_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// mii widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define NIBBLE_W 4           // mii data nibble.
`define NODE_ID_W 8          // node id and node count.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// plca timers, in TX_CLK cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define BEACON_CYCLES 20     // one beacon on the wire.
`define TO_CYCLES 20         // one transmit opportunity.
`define BEACON_DET_CYCLES 400 // follower gives up, back to resync.
`define STATUS_CYCLES 64     // status hold after plca_active drops.

// variable delay line.
// depth must cover beacon + node_count * to + frame.
`define DELAY_DEPTH 256
`define DELAY_AW 8

`endif

/* logic/mii_pkg.sv */
`default_nettype none

`include "plca_defs.svh"

package mii_pkg;

    // one mii transmit beat, mac side or phy side.
    typedef struct packed {
        logic                 en;   // tx_en.
        logic                 er;   // tx_er.
        logic [`NIBBLE_W-1:0] txd;  // data nibble.
    } mii_tx_t;

    // receive word as plain data.
    typedef struct packed {
        logic                 dv;
        logic                 er;
        logic [`NIBBLE_W-1:0] rxd;
    } mii_rx_data_t;

    // same word as a plca indication.
    typedef struct packed {
        logic                 dv;
        logic                 er;
        logic [`NIBBLE_W-1:0] code;
    } mii_rx_ind_t;

    typedef union packed {
        mii_rx_data_t data;
        mii_rx_ind_t  ind;
    } mii_rx_u;

    // indication codes, only with dv low and er high.
    localparam logic [`NIBBLE_W-1:0] IND_BEACON = 4'b0010;
    localparam logic [`NIBBLE_W-1:0] IND_COMMIT = 4'b0011;

endpackage

`default_nettype wire

/* logic/plca_pkg.sv */
`default_nettype none

`include "plca_defs.svh"

package plca_pkg;

    // management view of the node.
    typedef struct packed {
        logic                  en;          // plca_en.
        logic [`NODE_ID_W-1:0] local_id;    // 0 means coordinator.
        logic [`NODE_ID_W-1:0] node_count;  // used by node 0 only.
    } plca_cfg_t;

    // decoded receive indication.
    typedef enum logic [1:0] {
        RX_NONE,
        RX_BEACON,
        RX_COMMIT
    } rx_cmd_e;

    // control asks data for a beacon.
    typedef enum logic {
        TX_NONE,
        TX_BEACON
    } tx_cmd_e;

    typedef enum logic [2:0] {
        ST_DISABLE,
        ST_RESYNC,
        ST_SEND_BEACON,
        ST_SYNCING,
        ST_WAIT_TO,
        ST_TRANSMIT,
        ST_RECEIVE,
        ST_NEXT_TXOP
    } ctrl_state_e;

    // control to data.
    typedef struct packed {
        logic    committed;  // ack for packet_pending.
        tx_cmd_e tx_cmd;
    } ctrl_to_data_t;

endpackage

`default_nettype wire

/* logic/plca_rx_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module plca_rx_decode
    import mii_pkg::*;
    import plca_pkg::*;
(
    input  wire          TX_CLK,
    input  wire          rst_n,
    input  wire mii_rx_u phy_rx,
    output rx_cmd_e      rx_cmd,
    output logic         receiving
);

    rx_cmd_e cmd_d;

    // indication view of the word.
    always_comb
    begin
        cmd_d = RX_NONE;
        if (!phy_rx.ind.dv && phy_rx.ind.er)
        begin
            if (phy_rx.ind.code == IND_BEACON)
                cmd_d = RX_BEACON;
            else if (phy_rx.ind.code == IND_COMMIT)
                cmd_d = RX_COMMIT;
        end
    end

    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            rx_cmd    <= RX_NONE;
            receiving <= 1'b0;
        end
        else
        begin
            rx_cmd    <= cmd_d;                                     // one cycle late.
            receiving <= phy_rx.data.dv || (cmd_d == RX_COMMIT);   // data or commit.
        end
    end

    // a beacon ends in silence, never straight into data.
    a_beacon_no_dv: assert property (@(posedge TX_CLK) disable iff (!rst_n)
        (rx_cmd == RX_BEACON) |-> !phy_rx.data.dv);

endmodule

`default_nettype wire

/* logic/plca_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plca_defs.svh"

module plca_control
    import plca_pkg::*;
(
    input  wire           TX_CLK,
    input  wire           rst_n,
    input  wire plca_cfg_t cfg,
    input  wire rx_cmd_e  rx_cmd,
    input  wire           receiving,
    input  wire           packet_pending,
    output ctrl_to_data_t ctl,
    output logic          plca_active
);

    localparam int BCN_W = $clog2(`BEACON_CYCLES);
    localparam int TO_W  = $clog2(`TO_CYCLES);
    localparam int DET_W = $clog2(`BEACON_DET_CYCLES);

    ctrl_state_e           state;
    ctrl_state_e           adv_state;   // where an opportunity ends up.
    logic [BCN_W-1:0]      bcn_cnt;
    logic [TO_W-1:0]       to_cnt;
    logic [DET_W-1:0]      det_cnt;
    logic [`NODE_ID_W-1:0] cur_id;
    logic [`NODE_ID_W:0]   next_id;     // one bit wider for the wrap compare.
    logic                  coord;
    logic                  my_turn;
    logic                  last_txop;
    logic                  rx_beacon;
    logic                  bcn_done;
    logic                  to_done;
    logic                  det_done;
    logic                  det_run;
    logic                  follow_chk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign coord     = (cfg.local_id == '0);
    assign my_turn   = (cur_id == cfg.local_id);
    assign rx_beacon = (rx_cmd == RX_BEACON);
    assign next_id   = {1'b0, cur_id} + 1'b1;
    assign last_txop = coord && (next_id >= {1'b0, cfg.node_count});  // node 0 wraps.
    assign adv_state = last_txop ? ST_SEND_BEACON : ST_NEXT_TXOP;

    assign bcn_done = (bcn_cnt == BCN_W'(`BEACON_CYCLES - 1));
    assign to_done  = (to_cnt == TO_W'(`TO_CYCLES - 1));
    assign det_done = (det_cnt == DET_W'(`BEACON_DET_CYCLES - 1));

    // beacon watchdog, followers only.
    assign det_run    = !coord && !rx_beacon && (state != ST_DISABLE)
                        && (state != ST_RESYNC);
    assign follow_chk = !coord && (state != ST_DISABLE) && (state != ST_RESYNC)
                        && (state != ST_TRANSMIT);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opportunity fsm
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            state       <= ST_DISABLE;
            cur_id      <= '0;
            bcn_cnt     <= '0;
            to_cnt      <= '0;
            det_cnt     <= '0;
            plca_active <= 1'b0;
        end
        else if (!cfg.en)
        begin
            state       <= ST_DISABLE;
            det_cnt     <= '0;
            plca_active <= 1'b0;
        end
        else
        begin
            bcn_cnt <= (state == ST_SEND_BEACON) ? bcn_cnt + 1'b1 : '0;
            to_cnt  <= (state == ST_WAIT_TO) ? to_cnt + 1'b1 : TO_W'(1);  // 1st cycle spent.
            det_cnt <= det_run ? det_cnt + 1'b1 : '0;

            case (state)
                ST_DISABLE:
                    state <= ST_RESYNC;
                ST_RESYNC:
                begin
                    if (coord)
                    begin
                        state       <= ST_SEND_BEACON;  // node 0 owns the cycle.
                        plca_active <= 1'b1;
                    end
                    else if (rx_beacon)
                    begin
                        state       <= ST_SYNCING;
                        plca_active <= 1'b1;
                    end
                end
                ST_SEND_BEACON:
                    if (bcn_done) state <= ST_SYNCING;
                ST_SYNCING:
                begin
                    cur_id <= '0;
                    if (!rx_beacon) state <= ST_WAIT_TO;  // opportunity 0 starts.
                end
                ST_WAIT_TO:
                begin
                    if (receiving)
                        state <= ST_RECEIVE;        // medium busy, hold cur_id.
                    else if (my_turn && packet_pending)
                        state <= ST_TRANSMIT;       // commit.
                    else if (to_done)
                    begin
                        state  <= adv_state;
                        cur_id <= next_id[`NODE_ID_W-1:0];
                    end
                end
                ST_TRANSMIT:
                begin
                    if (!packet_pending)
                    begin
                        state  <= adv_state;        // handshake done.
                        cur_id <= next_id[`NODE_ID_W-1:0];
                    end
                end
                ST_RECEIVE:
                begin
                    if (!receiving)
                    begin
                        state  <= adv_state;
                        cur_id <= next_id[`NODE_ID_W-1:0];
                    end
                end
                ST_NEXT_TXOP:
                    state <= ST_WAIT_TO;
            endcase

            // followers resync to every beacon, or lose sync.
            if (follow_chk)
            begin
                if (rx_beacon)
                    state <= ST_SYNCING;
                else if (det_done)
                begin
                    state       <= ST_RESYNC;
                    plca_active <= 1'b0;
                end
            end
        end
    end

    assign ctl = '{committed: (state == ST_TRANSMIT),
                   tx_cmd:    (state == ST_SEND_BEACON) ? TX_BEACON : TX_NONE};

    // commit only answers a pending frame, in our own slot.
    a_commit_own_id: assert property (@(posedge TX_CLK) disable iff (!rst_n)
        $rose(ctl.committed) |-> $past(packet_pending) && (cur_id == cfg.local_id));

    // only the coordinator beacons.
    a_beacon_node0: assert property (@(posedge TX_CLK) disable iff (!rst_n)
        (ctl.tx_cmd == TX_BEACON) |-> (cfg.local_id == '0));

endmodule

`default_nettype wire

/* logic/plca_delay_line.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plca_defs.svh"

module plca_delay_line
(
    input  wire                  TX_CLK,
    input  wire                  rst_n,      // also clears pointers on disable.
    input  wire                  wr_en,
    input  wire [`NIBBLE_W-1:0]  wr_nibble,
    input  wire                  rd_en,
    output logic [`NIBBLE_W-1:0] rd_nibble,
    output logic                 empty
);

    logic [`NIBBLE_W-1:0] mem [`DELAY_DEPTH];
    logic [`DELAY_AW-1:0] wr_ptr;
    logic [`DELAY_AW-1:0] rd_ptr;
    logic [`DELAY_AW:0]   count;    // fill level, 0 to depth.

    // storage, no reset.
    always_ff @(posedge TX_CLK)
    begin
        if (wr_en) mem[wr_ptr] <= wr_nibble;
    end

    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth.
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            count <= count + wr_en - rd_en;
        end
    end

    assign rd_nibble = mem[rd_ptr];  // head of line.
    assign empty     = (count == '0);

    // mac must never outrun the wait.
    a_no_overflow: assert property (@(posedge TX_CLK) disable iff (!rst_n)
        (count == (`DELAY_AW+1)'(`DELAY_DEPTH)) |-> (!wr_en || rd_en));

endmodule

`default_nettype wire

/* logic/plca_data.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plca_defs.svh"

module plca_data
    import mii_pkg::*;
    import plca_pkg::*;
(
    input  wire                TX_CLK,
    input  wire                rst_n,
    input  wire plca_cfg_t     cfg,
    input  wire mii_tx_t       mac_tx,
    input  wire ctrl_to_data_t ctl,
    input  wire                receiving,
    output logic               packet_pending,
    output logic               mac_crs,
    output mii_tx_t            phy_tx
);

    // beacon symbol, en low, er high.
    localparam mii_tx_t BEACON_BEAT = '{en: 1'b0, er: 1'b1, txd: IND_BEACON};

    logic                 dl_rst_n;
    logic                 wr_en;
    logic                 rd_en;
    logic [`NIBBLE_W-1:0] rd_nibble;
    logic                 dl_empty;
    logic                 beacon;

    assign beacon   = cfg.en && (ctl.tx_cmd == TX_BEACON);  // never while disabling.
    assign dl_rst_n = rst_n && cfg.en;                       // drop stale nibbles.
    assign wr_en    = cfg.en && mac_tx.en;
    assign rd_en    = ctl.committed && packet_pending && !dl_empty;

    // defer the mac. own frame, medium busy or beacon.
    assign mac_crs = receiving || mac_tx.en || packet_pending || beacon;

    plca_delay_line u_delay_line
    (
        .TX_CLK    (TX_CLK),
        .rst_n     (dl_rst_n),
        .wr_en     (wr_en),
        .wr_nibble (mac_tx.txd),
        .rd_en     (rd_en),
        .rd_nibble (rd_nibble),
        .empty     (dl_empty)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packet_pending handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
            packet_pending <= 1'b0;
        else if (!cfg.en)
            packet_pending <= 1'b0;
        else if (!packet_pending)
            packet_pending <= !ctl.committed && (mac_tx.en || !dl_empty);  // wait for ack low.
        else if (ctl.committed && dl_empty && !mac_tx.en)
            packet_pending <= 1'b0;  // last nibble out last cycle.
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mii output mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
            phy_tx <= '0;
        else if (!cfg.en)
            phy_tx <= mac_tx;       // plain rs, straight through.
        else if (beacon)
            phy_tx <= BEACON_BEAT;
        else
            phy_tx <= '{en: rd_en, er: 1'b0, txd: rd_en ? rd_nibble : '0};
    end

endmodule

`default_nettype wire

/* logic/plca_status.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plca_defs.svh"

module plca_status
    import plca_pkg::*;
(
    input  wire            TX_CLK,
    input  wire            rst_n,
    input  wire plca_cfg_t cfg,
    input  wire            plca_active,
    output logic           plca_status   // high is OK, low is FAIL.
);

    localparam int HOLD_W = $clog2(`STATUS_CYCLES);

    logic [HOLD_W-1:0] hold_cnt;

    always_ff @(posedge TX_CLK)
    begin
        if (!rst_n)
        begin
            plca_status <= 1'b0;
            hold_cnt    <= '0;
        end
        else if (!cfg.en)
        begin
            plca_status <= 1'b0;    // admin off, fail at once.
            hold_cnt    <= '0;
        end
        else if (!plca_status)
        begin
            hold_cnt <= '0;
            if (plca_active) plca_status <= 1'b1;
        end
        else if (plca_active)
            hold_cnt <= '0;         // still synced.
        else if (hold_cnt == HOLD_W'(`STATUS_CYCLES - 1))
            plca_status <= 1'b0;    // hold ran out.
        else
            hold_cnt <= hold_cnt + 1'b1;
    end

endmodule

`default_nettype wire

/* logic/plca_top.sv */
`timescale 1ns/1ps
`default_nettype none

module plca_top
    import mii_pkg::*;
    import plca_pkg::*;
(
    input  wire            TX_CLK,
    input  wire            rst_n,
    input  wire plca_cfg_t cfg,
    input  wire mii_tx_t   mac_tx,
    input  wire mii_rx_u   phy_rx,
    output mii_tx_t        phy_tx,
    output logic           mac_crs,
    output logic           plca_status
);

    rx_cmd_e       rx_cmd;
    logic          receiving;
    logic          packet_pending;
    logic          plca_active;
    ctrl_to_data_t ctl;

    plca_rx_decode u_rx_decode
    (
        .TX_CLK    (TX_CLK),
        .rst_n     (rst_n),
        .phy_rx    (phy_rx),
        .rx_cmd    (rx_cmd),
        .receiving (receiving)
    );

    plca_control u_control
    (
        .TX_CLK         (TX_CLK),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .rx_cmd         (rx_cmd),
        .receiving      (receiving),
        .packet_pending (packet_pending),
        .ctl            (ctl),
        .plca_active    (plca_active)
    );

    plca_data u_data
    (
        .TX_CLK         (TX_CLK),
        .rst_n          (rst_n),
        .cfg            (cfg),
        .mac_tx         (mac_tx),
        .ctl            (ctl),
        .receiving      (receiving),
        .packet_pending (packet_pending),
        .mac_crs        (mac_crs),
        .phy_tx         (phy_tx)
    );

    plca_status u_status
    (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .plca_active (plca_active),
        .plca_status (plca_status)
    );

endmodule

`default_nettype wire

/* testbench/plca_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "plca_defs.svh"

module plca_tb
    import mii_pkg::*;
    import plca_pkg::*;
();

    localparam int PERIOD   = `BEACON_CYCLES + 4 * `TO_CYCLES;  // idle cycle, node_count 4.
    localparam int MAX_LEN  = 40;   // keeps wait + frame inside the delay line.
    localparam int MAX_GAP  = 30;
    localparam int N_FRAMES = 10;
    localparam int N_MIXED  = 12;
    localparam int N_FOLLOW = 5;
    // worst case per test, plus margin.
    localparam int LIMIT    = 6 * PERIOD
                            + (2 * N_FRAMES + N_MIXED) * (PERIOD + 2 * MAX_LEN + MAX_GAP)
                            + (N_FOLLOW + 3) * PERIOD + 4 * PERIOD + 1000;

    logic      TX_CLK;
    logic      rst_n;
    plca_cfg_t cfg;
    mii_tx_t   mac_tx;
    mii_rx_u   phy_rx;
    mii_tx_t   phy_tx;
    logic      mac_crs;
    logic      plca_status;
    logic      rx_bcn_word;

    integer               seed;
    int                   cycles, checks, errors, test_errors;
    int                   frames_sent, frames_seen;
    logic [`NIBBLE_W-1:0] exp_q[$];   // model, nibbles in mac order.
    int                   len_q[$];   // model, frame lengths.
    bit                   period_chk, follower, frames_done, have_start;
    bit                   outstanding, prev_en, prev_er, prev_crs, prev_dv, crs_seen;
    int                   burst_len, bcn_len, last_start, bcn_starts, since_bcn;
    int                   since_tx_bcn;

    plca_top UUT
    (
        .TX_CLK      (TX_CLK),
        .rst_n       (rst_n),
        .cfg         (cfg),
        .mac_tx      (mac_tx),
        .phy_rx      (phy_rx),
        .phy_tx      (phy_tx),
        .mac_crs     (mac_crs),
        .plca_status (plca_status)
    );

    initial TX_CLK = 1'b0;
    always #2 TX_CLK = ~TX_CLK;  // 4 ns period.

    assign rx_bcn_word = !phy_rx.ind.dv && phy_rx.ind.er && (phy_rx.ind.code == IND_BEACON);

    // run limit.
    always @(posedge TX_CLK)
    begin
        cycles = cycles + 1;
        if (cycles >= LIMIT)
        begin
            $display("timeout after %0d cycles, a test never finished", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // check helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_val(input string name, input int exp, input int got);
        checks++;
        assert (exp == got)
        else
        begin
            errors++;
            $display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond)
        else
        begin
            errors++;
            $display("ERROR at %0t: %s", $time, what);
        end
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_errors)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        test_errors = errors;
    endtask

    function automatic int rand_range(input int lo, input int hi);
        rand_range = lo + ($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // monitor, samples on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge TX_CLK)
    begin
        if (rst_n)
        begin
            since_bcn = rx_bcn_word ? 0 : since_bcn + 1;  // cycles since last rx beacon word.
            since_tx_bcn = phy_tx.er ? 0 : since_tx_bcn + 1;  // since our own beacon.
            if (phy_tx.en)
            begin
                check_true(!phy_tx.er, "tx_er raised inside a frame");
                check_true(mac_crs, "mac_crs low while a frame is on the mii");
                check_true(!prev_dv, "transmit in the cycle after a received nibble");
                if (!prev_en && follower)
                    check_true(since_bcn >= 2 * `TO_CYCLES && !rx_bcn_word,
                               "follower frame started outside its opportunity");
                if (exp_q.size() == 0)
                    check_true(1'b0, "nibble on phy_tx with no frame queued");
                else
                    check_val("phy_tx.txd", exp_q.pop_front(), phy_tx.txd);
                burst_len++;
            end
            else if (prev_en)
            begin
                // frame just ended.
                frames_seen++;
                outstanding = 1'b0;
                if (len_q.size() != 0)
                    check_val("frame length", len_q.pop_front(), burst_len);
                burst_len = 0;
            end

            if (phy_tx.er)
            begin
                check_true(!follower, "follower node sent a beacon");
                check_true(prev_crs, "mac_crs low while a beacon was sent");  // crs leads mii.
                check_val("phy_tx.en", 0, phy_tx.en);
                check_val("phy_tx.txd", IND_BEACON, phy_tx.txd);
                if (!prev_er)
                begin
                    if (period_chk && have_start)
                        check_val("beacon period", PERIOD, cycles - last_start);
                    have_start = 1'b1;
                    last_start = cycles;
                    bcn_starts++;
                end
                bcn_len++;
            end
            else if (prev_er)
            begin
                if (cfg.en)
                    check_val("beacon length", `BEACON_CYCLES, bcn_len);  // cut short on disable.
                bcn_len = 0;
            end

            if (mac_tx.en)
                outstanding = 1'b1;
            if (outstanding)
                check_true(mac_crs, "mac_crs low while a frame is pending");

            prev_en  = phy_tx.en;
            prev_er  = phy_tx.er;
            prev_crs = mac_crs;
            prev_dv  = phy_rx.data.dv;
        end
        crs_seen = mac_crs;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge TX_CLK);
    endtask

    // mac or remote node only starts on a quiet carrier.
    task automatic wait_idle();
        @(posedge TX_CLK);
        while (crs_seen)
            @(posedge TX_CLK);
    endtask

    task automatic send_frame(input int len);
        logic [`NIBBLE_W-1:0] nib;
        wait_idle();
        len_q.push_back(len);
        frames_sent++;
        repeat (len)
        begin
            nib = 4'($random(seed));
            mac_tx <= '{en: 1'b1, er: 1'b0, txd: nib};
            exp_q.push_back(nib);
            @(posedge TX_CLK);
        end
        mac_tx <= '0;
    endtask

    // remote node talks on a quiet medium, or in a later slot
    // while our own frame still waits for slot 0.
    task automatic recv_burst(input int len);
        @(posedge TX_CLK);
        while (crs_seen && !(outstanding && !prev_en
                             && since_tx_bcn > `TO_CYCLES + 4
                             && since_tx_bcn <= 3 * `TO_CYCLES))
            @(posedge TX_CLK);
        repeat (len)
        begin
            phy_rx <= {1'b1, 1'b0, 4'($random(seed))};  // dv high, plain data.
            @(posedge TX_CLK);
        end
        phy_rx <= '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || outstanding)
            @(negedge TX_CLK);
    endtask

    // remote coordinator, one beacon per idle period.
    task automatic drive_beacons();
        @(posedge TX_CLK);
        while (!frames_done)
        begin
            repeat (`BEACON_CYCLES)
            begin
                phy_rx <= {1'b0, 1'b1, IND_BEACON};
                @(posedge TX_CLK);
            end
            phy_rx <= '0;
            repeat (PERIOD - `BEACON_CYCLES) @(posedge TX_CLK);
        end
    endtask

    initial
    begin
        int i;
        seed        = 32'ha76a_c5d7;
        rst_n       = 1'b0;
        cfg         = '{en: 1'b1, local_id: 8'd0, node_count: 8'd4};
        mac_tx      = '0;
        phy_rx      = '0;
        cycles      = 0;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        since_bcn   = 0;
        since_tx_bcn = 0;
        repeat (3) @(posedge TX_CLK);
        rst_n <= 1'b1;

        // node 0, no traffic.
        period_chk = 1'b1;
        while (bcn_starts < 5)
            @(negedge TX_CLK);
        period_chk = 1'b0;
        report_test(1, "beacon period");

        for (i = 0; i < N_FRAMES; i++)
        begin
            send_frame(rand_range(1, MAX_LEN));
            wait_cycles(rand_range(1, MAX_GAP));
        end
        wait_drain();
        check_val("frames seen", frames_sent, frames_seen);
        report_test(2, "frame integrity");

        // back to back, mac restarts as soon as crs drops.
        for (i = 0; i < N_FRAMES; i++)
            send_frame(rand_range(1, MAX_LEN));
        wait_drain();
        check_val("frames seen", frames_sent, frames_seen);
        report_test(3, "carrier deferral");

        for (i = 0; i < N_MIXED; i++)
        begin
            if ($random(seed) & 1)
                recv_burst(rand_range(4, 30));
            else
                send_frame(rand_range(1, MAX_LEN));
            wait_cycles(rand_range(2, MAX_GAP));
        end
        wait_drain();
        check_val("frames seen", frames_sent, frames_seen);
        report_test(4, "yield to medium");

        // follower, local_id 2.
        @(posedge TX_CLK);
        cfg.en <= 1'b0;
        wait_cycles(4);
        cfg         <= '{en: 1'b1, local_id: 8'd2, node_count: 8'd4};
        follower    = 1'b1;
        frames_done = 1'b0;
        fork
            drive_beacons();
            begin
                for (i = 0; i < N_FOLLOW; i++)
                begin
                    send_frame(rand_range(2, 16));  // fits between slot 2 and next beacon.
                    wait_cycles(rand_range(0, 20));
                end
                wait_drain();
                frames_done = 1'b1;
            end
        join
        follower = 1'b0;
        check_val("frames seen", frames_sent, frames_seen);
        report_test(5, "follower node");

        // status, from a disabled node 0.
        @(posedge TX_CLK);
        cfg.en <= 1'b0;
        phy_rx <= '0;
        wait_cycles(4);
        @(negedge TX_CLK);
        check_val("plca_status", 0, plca_status);
        @(posedge TX_CLK);
        cfg <= '{en: 1'b1, local_id: 8'd0, node_count: 8'd4};
        @(negedge TX_CLK);
        while (!phy_tx.er)
        begin
            check_val("plca_status", 0, plca_status);
            @(negedge TX_CLK);
        end
        while (phy_tx.er)
            @(negedge TX_CLK);
        check_val("plca_status", 1, plca_status);
        while (!phy_tx.er)
            @(negedge TX_CLK);  // drop en inside the next beacon.
        @(posedge TX_CLK);
        cfg.en <= 1'b0;
        @(negedge TX_CLK);
        check_val("plca_status", 1, plca_status);
        repeat (8)
        begin
            @(negedge TX_CLK);
            check_val("plca_status", 0, plca_status);
            check_val("phy_tx.er", 0, phy_tx.er);
        end
        report_test(6, "status");

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
+incdir+include
logic/mii_pkg.sv
logic/plca_pkg.sv
logic/plca_rx_decode.sv
logic/plca_control.sv
logic/plca_delay_line.sv
logic/plca_data.sv
logic/plca_status.sv
logic/plca_top.sv
testbench/plca_tb.sv

/* run.sh */
#!/bin/sh
# build and run the plca testbench with verilator, from the project root.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f list.f --top-module plca_tb -o plca_sim \
    && ./obj_dir/plca_sim | tee /dev/stderr | grep -q "ALL CHECKS PASSED" \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }
